// File: common/predictorPkg.sv
/*
 * Shared widths, types and constants of the branch-prediction front end
 */
package predictorPkg;

    // Table geometry
    localparam int BTB_ENTRIES = 32;
    localparam int GHR_BITS    = 5;

    // Lowest PC bit used to index the tables
    localparam int IDX_LSB = 2;

    // Instruction address or PC-relative offset
    typedef logic [31:0] addrT;

    typedef logic [6:0] opcodeT;

    // Index into the BTB or the PHT
    typedef logic [$clog2(BTB_ENTRIES)-1:0] tableIdxT;

    // Global branch history
    typedef logic [GHR_BITS-1:0] historyT;

    // 2-bit saturating counter, top bit is the taken prediction
    typedef logic [1:0] counterT;

    // Opcodes the front end cares about
    localparam opcodeT OP_BRANCH = 7'b1100011;
    localparam opcodeT OP_JAL    = 7'b1101111;

    localparam addrT RESET_PC    = 32'h0000_1000;
    localparam addrT INSTR_BYTES = 32'd4;

    // Weakly not taken
    localparam counterT COUNTER_INIT = 2'b01;

endpackage

// File: common/predictorUpdateIf.sv
/*
 * Table update bus from the execute-stage resolver to the BTB and the PHT
 */
`timescale 1ns/1ps

interface predictorUpdateIf;
    import predictorPkg::*;

    // BTB write port
    logic     btbWe;
    tableIdxT btbIdx;
    addrT     btbTarget;

    // PHT counter update and history clear
    logic     phtWe;
    tableIdxT phtIdx;
    logic     phtTaken;
    logic     ghrClear;

    modport resolver (
        output btbWe, btbIdx, btbTarget,
        output phtWe, phtIdx, phtTaken, ghrClear
    );

    modport btb (input btbWe, btbIdx, btbTarget);

    modport pht (input phtWe, phtIdx, phtTaken, ghrClear);

endinterface

// File: predictor/branchTargetBuffer.sv
/*
 * Direct-mapped branch target buffer with valid bits,
 * combinational read at fetch and write at resolve
 */
`timescale 1ns/1ps

module branchTargetBuffer (
    input  logic                  clk,
    input  logic                  reset,
    input  predictorPkg::tableIdxT readIdx_i,
    output logic                  hit_o,
    output predictorPkg::addrT    target_o,
    predictorUpdateIf.btb         upd
);
    import predictorPkg::*;

    logic validBits [BTB_ENTRIES];
    addrT targets [BTB_ENTRIES];

    // Valid bits are control state and clear on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                validBits[i] <= 1'b0;
            end
        end else if (upd.btbWe) begin
            validBits[upd.btbIdx] <= 1'b1;
        end
    end

    // Target storage
    always_ff @(posedge clk) begin
        if (upd.btbWe) begin
            targets[upd.btbIdx] <= upd.btbTarget;
        end
    end

    // Read port, a write lands for the next cycle's read
    assign hit_o    = validBits[readIdx_i];
    assign target_o = targets[readIdx_i];

endmodule

// File: predictor/gsharePht.sv
/*
 * Global history register and pattern history table of
 * 2-bit saturating counters with gshare indexing
 */
`timescale 1ns/1ps

module gsharePht (
    input  logic                   clk,
    input  logic                   reset,
    input  predictorPkg::addrT     pc_i,
    input  logic                   shift_i,
    input  logic                   shiftTaken_i,
    output predictorPkg::tableIdxT readIdx_o,
    output logic                   counterTaken_o,
    predictorUpdateIf.pht          upd
);
    import predictorPkg::*;

    historyT ghr;
    counterT counters [BTB_ENTRIES];
    counterT oldCount;

    // Clear on mispredict wins over the speculative shift
    always_ff @(posedge clk) begin
        if (reset) begin
            ghr <= '0;
        end else if (upd.ghrClear) begin
            ghr <= '0;
        end else if (shift_i) begin
            ghr <= {ghr[GHR_BITS-2:0], shiftTaken_i};
        end
    end

    // gshare index from PC bits and history
    assign readIdx_o      = pc_i[IDX_LSB +: $bits(tableIdxT)] ^ ghr;
    assign counterTaken_o = counters[readIdx_o][1];

    assign oldCount = counters[upd.phtIdx];

    // Saturating update at the index carried down from fetch
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                counters[i] <= COUNTER_INIT;
            end
        end else if (upd.phtWe) begin
            if (upd.phtTaken) begin
                if (oldCount != 2'b11) begin
                    counters[upd.phtIdx] <= oldCount + 2'd1;
                end
            end else begin
                if (oldCount != 2'b00) begin
                    counters[upd.phtIdx] <= oldCount - 2'd1;
                end
            end
        end
    end

    // History is empty after a mispredict, whatever was fetched that cycle
    ghrClearWins: assert property (
        @(posedge clk) disable iff (reset)
        upd.ghrClear |=> (ghr == '0)
    );

endmodule

// File: source/fetchPc.sv
/*
 * Fetch PC register and next-PC selection
 */
`timescale 1ns/1ps

module fetchPc (
    input  logic               clk,
    input  logic               reset,
    input  logic               stall_i,
    input  logic               btbHit_i,
    input  predictorPkg::addrT btbTarget_i,
    input  logic               counterTaken_i,
    input  logic               mispredict_i,
    input  predictorPkg::addrT redirectPc_i,
    output predictorPkg::addrT pc_o,
    output logic               predTaken_o,
    output predictorPkg::addrT predTarget_o
);
    import predictorPkg::*;

    // Taken only with a valid target and a strong enough counter
    assign predTaken_o  = btbHit_i & counterTaken_i;
    assign predTarget_o = predTaken_o ? btbTarget_i : pc_o + INSTR_BYTES;

    // Redirect overrides stall
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_o <= RESET_PC;
        end else if (mispredict_i) begin
            pc_o <= redirectPc_i;
        end else if (!stall_i) begin
            pc_o <= predTarget_o;
        end
    end

    // Holds as long as BTB targets and redirects are word aligned
    pcAligned: assert property (
        @(posedge clk) disable iff (reset)
        pc_o[1:0] == 2'b00
    );

endmodule

// File: source/predictionPipe.sv
/*
 * Opcode classification and the decode and execute registers
 * that carry prediction state down to the resolver
 */
`timescale 1ns/1ps

module predictionPipe (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall_i,
    input  logic                   mispredict_i,
    input  predictorPkg::opcodeT   opF_i,
    input  predictorPkg::addrT     offsetF_i,
    input  predictorPkg::addrT     pcF_i,
    input  logic                   predTakenF_i,
    input  predictorPkg::addrT     predTargetF_i,
    input  predictorPkg::tableIdxT phtIdxF_i,
    output logic                   ghrShift_o,
    output logic                   isBranchE_o,
    output logic                   isJalE_o,
    output predictorPkg::addrT     pcE_o,
    output predictorPkg::addrT     offsetE_o,
    output logic                   predTakenE_o,
    output predictorPkg::addrT     predTargetE_o,
    output predictorPkg::tableIdxT phtIdxE_o
);
    import predictorPkg::*;

    logic     isBranchF, isJalF;
    logic     isBranchD, isJalD;
    addrT     pcD, offsetD, predTargetD;
    logic     predTakenD;
    tableIdxT phtIdxD;

    assign isBranchF = (opF_i == OP_BRANCH);
    assign isJalF    = (opF_i == OP_JAL);

    // Speculative history update only for branches that really leave fetch
    assign ghrShift_o = isBranchF & ~stall_i & ~mispredict_i;

    // Decode class bits, bubble on flush, hold on stall
    always_ff @(posedge clk) begin
        if (reset || mispredict_i) begin
            isBranchD <= 1'b0;
            isJalD    <= 1'b0;
        end else if (!stall_i) begin
            isBranchD <= isBranchF;
            isJalD    <= isJalF;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            pcD         <= pcF_i;
            offsetD     <= offsetF_i;
            predTakenD  <= predTakenF_i;
            predTargetD <= predTargetF_i;
            phtIdxD     <= phtIdxF_i;
        end
    end

    // Execute class bits, a stall leaves a bubble behind
    always_ff @(posedge clk) begin
        if (reset || mispredict_i || stall_i) begin
            isBranchE_o <= 1'b0;
            isJalE_o    <= 1'b0;
        end else begin
            isBranchE_o <= isBranchD;
            isJalE_o    <= isJalD;
        end
    end

    // Payload only matters when a class bit is set
    always_ff @(posedge clk) begin
        pcE_o         <= pcD;
        offsetE_o     <= offsetD;
        predTakenE_o  <= predTakenD;
        predTargetE_o <= predTargetD;
        phtIdxE_o     <= phtIdxD;
    end

    execOneClass: assert property (
        @(posedge clk) disable iff (reset)
        !(isBranchE_o && isJalE_o)
    );

endmodule

// File: source/branchResolve.sv
/*
 * Execute-stage branch resolution: outcome, mispredict,
 * redirect PC and table update generation
 */
`timescale 1ns/1ps

module branchResolve (
    input  logic                   isBranchE_i,
    input  logic                   isJalE_i,
    input  logic                   takenE_i,
    input  predictorPkg::addrT     pcE_i,
    input  predictorPkg::addrT     offsetE_i,
    input  logic                   predTakenE_i,
    input  predictorPkg::addrT     predTargetE_i,
    input  predictorPkg::tableIdxT phtIdxE_i,
    output logic                   mispredict_o,
    output predictorPkg::addrT     redirectPc_o,
    predictorUpdateIf.resolver     upd
);
    import predictorPkg::*;

    logic isControl;
    logic actualTaken;
    logic wrongDir;
    logic wrongTarget;
    addrT actualTarget;

    assign isControl    = isBranchE_i | isJalE_i;
    // JAL always taken
    assign actualTaken  = isJalE_i | (isBranchE_i & takenE_i);
    assign actualTarget = pcE_i + offsetE_i;

    assign wrongDir    = predTakenE_i != actualTaken;
    // Right direction but stale BTB target
    assign wrongTarget = predTakenE_i & actualTaken & (predTargetE_i != actualTarget);

    assign mispredict_o = isControl & (wrongDir | wrongTarget);
    assign redirectPc_o = actualTaken ? actualTarget : pcE_i + INSTR_BYTES;

    // BTB learns every taken target
    assign upd.btbWe     = actualTaken;
    assign upd.btbIdx    = pcE_i[IDX_LSB +: $bits(tableIdxT)];
    assign upd.btbTarget = actualTarget;

    // Counters train on conditional branches only
    assign upd.phtWe    = isBranchE_i;
    assign upd.phtIdx   = phtIdxE_i;
    assign upd.phtTaken = takenE_i;

    assign upd.ghrClear = mispredict_o;

endmodule

// File: source/fetchFrontEnd.sv
/*
 * Branch-prediction front end: fetch PC, BTB, gshare PHT,
 * prediction pipeline and execute-stage resolver
 */
`timescale 1ns/1ps

module fetchFrontEnd (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stallF_i,
    input  predictorPkg::opcodeT opF_i,
    input  predictorPkg::addrT   offsetF_i,
    input  logic                 takenE_i,
    output predictorPkg::addrT   pcF_o,
    output logic                 predTakenF_o,
    output logic                 mispredict_o
);
    import predictorPkg::*;

    // Fetch stage
    logic     btbHit;
    addrT     btbTarget;
    logic     counterTaken;
    addrT     predTargetF;
    tableIdxT phtIdxF;
    logic     ghrShift;

    // Execute stage
    logic     isBranchE, isJalE;
    addrT     pcE, offsetE, predTargetE;
    logic     predTakenE;
    tableIdxT phtIdxE;
    addrT     redirectPc;

    predictorUpdateIf updBus ();

    fetchPc pcReg (
        .clk(clk), .reset(reset),
        .stall_i(stallF_i),
        .btbHit_i(btbHit), .btbTarget_i(btbTarget),
        .counterTaken_i(counterTaken),
        .mispredict_i(mispredict_o), .redirectPc_i(redirectPc),
        .pc_o(pcF_o), .predTaken_o(predTakenF_o), .predTarget_o(predTargetF)
    );

    // BTB indexed by PC bits 6 down to 2
    branchTargetBuffer btb (
        .clk(clk), .reset(reset),
        .readIdx_i(pcF_o[IDX_LSB +: $bits(tableIdxT)]),
        .hit_o(btbHit), .target_o(btbTarget),
        .upd(updBus.btb)
    );

    gsharePht pht (
        .clk(clk), .reset(reset),
        .pc_i(pcF_o),
        .shift_i(ghrShift), .shiftTaken_i(predTakenF_o),
        .readIdx_o(phtIdxF), .counterTaken_o(counterTaken),
        .upd(updBus.pht)
    );

    predictionPipe pipe (
        .clk(clk), .reset(reset),
        .stall_i(stallF_i), .mispredict_i(mispredict_o),
        .opF_i(opF_i), .offsetF_i(offsetF_i), .pcF_i(pcF_o),
        .predTakenF_i(predTakenF_o), .predTargetF_i(predTargetF),
        .phtIdxF_i(phtIdxF),
        .ghrShift_o(ghrShift),
        .isBranchE_o(isBranchE), .isJalE_o(isJalE),
        .pcE_o(pcE), .offsetE_o(offsetE),
        .predTakenE_o(predTakenE), .predTargetE_o(predTargetE),
        .phtIdxE_o(phtIdxE)
    );

    branchResolve resolve (
        .isBranchE_i(isBranchE), .isJalE_i(isJalE), .takenE_i(takenE_i),
        .pcE_i(pcE), .offsetE_i(offsetE),
        .predTakenE_i(predTakenE), .predTargetE_i(predTargetE),
        .phtIdxE_i(phtIdxE),
        .mispredict_o(mispredict_o), .redirectPc_o(redirectPc),
        .upd(updBus.resolver)
    );

endmodule

// File: bench/frontEndModel.svh
/*
 * Reference model of the fetch PC, BTB, gshare PHT and the
 * decode and execute prediction registers
 */
`ifndef FRONT_END_MODEL_SVH
`define FRONT_END_MODEL_SVH

// Table and fetch state
logic [31:0] mPc;
logic        mValid [32];
logic [31:0] mTarget [32];
logic [1:0]  mCount [32];
logic [4:0]  mGhr;

// Decode and execute registers
logic        mBrD, mJalD, mPredD, mBrE, mJalE, mPredE;
logic [31:0] mPcD, mOffD, mPredTgtD, mPcE, mOffE, mPredTgtE;
logic [4:0]  mIdxD, mIdxE;

// Values of the current cycle
logic        mPredTaken, mMispredict, mActTaken;
logic [31:0] mPredTarget, mRedirect, mActTarget;
logic [4:0]  mPhtIdx;

task automatic resetModel;
    mPc = 32'h0000_1000;
    mGhr = '0;
    for (int i = 0; i < 32; i++) begin
        mValid[i] = 1'b0;
        mTarget[i] = '0;
        mCount[i] = 2'b01;
    end
    {mBrD, mJalD, mPredD, mBrE, mJalE, mPredE} = '0;
    {mPcD, mOffD, mPredTgtD, mPcE, mOffE, mPredTgtE} = '0;
    {mIdxD, mIdxE} = '0;
endtask

// Prediction at fetch and resolution in execute
task automatic evalModel(input logic takenE);
    logic [4:0] idxF;
    idxF = mPc[6:2];
    mPhtIdx = idxF ^ mGhr;
    mPredTaken = mValid[idxF] && mCount[mPhtIdx][1];
    mPredTarget = mPredTaken ? mTarget[idxF] : mPc + 32'd4;
    mActTaken = mJalE || (mBrE && takenE);
    mActTarget = mPcE + mOffE;
    mMispredict = (mBrE || mJalE) &&
        ((mPredE != mActTaken) || (mPredE && mActTaken && (mPredTgtE != mActTarget)));
    mRedirect = mActTaken ? mActTarget : mPcE + 32'd4;
endtask

// Clock edge, using the values from evalModel
task automatic stepModel(input logic [6:0] op, input logic [31:0] off,
                         input logic stall, input logic takenE);
    if (mActTaken) begin
        mValid[mPcE[6:2]] = 1'b1;
        mTarget[mPcE[6:2]] = mActTarget;
    end
    if (mBrE) begin
        if (takenE && mCount[mIdxE] != 2'b11) mCount[mIdxE] = mCount[mIdxE] + 2'd1;
        if (!takenE && mCount[mIdxE] != 2'b00) mCount[mIdxE] = mCount[mIdxE] - 2'd1;
    end
    if (mMispredict) begin
        mGhr = '0;
    end else if (op == OP_BRANCH && !stall) begin
        mGhr = {mGhr[3:0], mPredTaken};
    end
    // Execute takes decode unless flushed or stalled
    mBrE = mBrD && !mMispredict && !stall;
    mJalE = mJalD && !mMispredict && !stall;
    {mPcE, mOffE, mPredE, mPredTgtE, mIdxE} = {mPcD, mOffD, mPredD, mPredTgtD, mIdxD};
    if (mMispredict) begin
        {mBrD, mJalD} = 2'b00;
    end else if (!stall) begin
        mBrD = (op == OP_BRANCH);
        mJalD = (op == OP_JAL);
    end
    if (!stall) begin
        {mPcD, mOffD, mPredD, mPredTgtD, mIdxD} = {mPc, off, mPredTaken, mPredTarget, mPhtIdx};
    end
    if (mMispredict) begin
        mPc = mRedirect;
    end else if (!stall) begin
        mPc = mPredTarget;
    end
endtask

`endif

// File: bench/frontEndTb.sv
/*
 * Testbench for the branch-prediction front end with directed
 * tests, LFSR random stimulus and a reference model
 */
`timescale 1ns/1ps

module frontEndTb;
    import predictorPkg::*;

    localparam int CYCLE_LIMIT = 2500;
    localparam logic [6:0] OP_OTHER = 7'b0010011;

    logic clk = 1'b0;
    logic reset;
    logic stallF, takenE;
    opcodeT opF;
    addrT offsetF, pcF;
    logic predTakenF, mispredict;

    int cycleCount = 0;
    logic [31:0] lfsr = 32'd90084;

    `include "frontEndModel.svh"

    fetchFrontEnd UUT (
        .clk(clk), .reset(reset),
        .stallF_i(stallF), .opF_i(opF), .offsetF_i(offsetF), .takenE_i(takenE),
        .pcF_o(pcF), .predTakenF_o(predTakenF), .mispredict_o(mispredict)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("CHECKS FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Galois LFSR, one step per bit
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'hD000_0001) : (state >> 1);
    endfunction

    task automatic drawBits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsrNext(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    // Compare the outputs of this cycle, then advance the model
    task automatic compareAndStep(input string name);
        evalModel(takenE);
        checkValue({name, " pcF"}, mPc, pcF);
        checkValue({name, " predTakenF"}, 32'(mPredTaken), 32'(predTakenF));
        checkValue({name, " mispredict"}, 32'(mMispredict), 32'(mispredict));
        stepModel(opF, offsetF, stallF, takenE);
    endtask

    task automatic runCycle(input string name, input logic [6:0] op, input logic [31:0] off,
                            input logic taken, input logic stall);
        @(negedge clk);
        opF = op;
        offsetF = off;
        takenE = taken;
        stallF = stall;
        #1;
        compareAndStep(name);
    endtask

    initial begin
        logic [31:0] pick, offs, tk, st, expPc, brPc;
        logic [6:0] op;
        reset = 1'b1;
        stallF = 1'b0;
        takenE = 1'b0;
        opF = OP_OTHER;
        offsetF = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;
        checkValue("reset pcF", RESET_PC, pcF);
        checkValue("reset predTakenF", 0, 32'(predTakenF));
        checkValue("reset mispredict", 0, 32'(mispredict));
        resetModel();
        compareAndStep("reset");

        // Plain instructions only
        expPc = RESET_PC;
        for (int i = 0; i < 20; i++) begin
            runCycle("sequential", OP_OTHER, 0, 0, 0);
            expPc = expPc + 32'd4;
            checkValue("sequential pcF", expPc, pcF);
            checkValue("sequential mispredict", 0, 32'(mispredict));
        end

        // Taken branch followed by two JALs that must be flushed
        runCycle("redirect", OP_BRANCH, 32, 1, 0);
        brPc = pcF;
        runCycle("redirect", OP_JAL, 8, 1, 0);
        runCycle("redirect", OP_JAL, 8, 1, 0);
        checkValue("redirect mispredict", 1, 32'(mispredict));
        for (int i = 0; i < 3; i++) begin
            runCycle("redirect", OP_OTHER, 0, 1, 0);
            if (i == 0) checkValue("redirect pcF", brPc + 32'd32, pcF);
            checkValue("redirect flush", 0, 32'(mispredict));
        end

        // Self-loop branch trains the BTB and the counters
        for (int i = 0; i < 60; i++) begin
            runCycle("training", OP_BRANCH, 0, 1, 0);
            if (i >= 50) begin
                checkValue("training predTakenF", 1, 32'(predTakenF));
                checkValue("training mispredict", 0, 32'(mispredict));
            end
        end

        // Mispredict during a stall redirects, later stalls hold the PC
        runCycle("stall", OP_BRANCH, 16, 1, 0);
        brPc = pcF;
        runCycle("stall", OP_OTHER, 0, 1, 0);
        runCycle("stall", OP_OTHER, 0, 1, 1);
        checkValue("stall mispredict", 1, 32'(mispredict));
        for (int i = 0; i < 6; i++) begin
            runCycle("stall", OP_OTHER, 0, 0, 1);
            checkValue("stall pcF", brPc + 32'd16, pcF);
        end

        for (int i = 0; i < 2000; i++) begin
            drawBits(2, pick);
            drawBits(5, offs);
            drawBits(1, tk);
            drawBits(3, st);
            op = (pick[1:0] == 2'd0) ? OP_BRANCH : (pick[1:0] == 2'd1) ? OP_JAL : OP_OTHER;
            runCycle("random", op, {{25{offs[4]}}, offs[4:0], 2'b00}, tk[0], st[2:0] == 3'd0);
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: all.f
+incdir+bench
common/predictorPkg.sv
common/predictorUpdateIf.sv
predictor/branchTargetBuffer.sv
predictor/gsharePht.sv
source/fetchPc.sv
source/predictionPipe.sv
source/branchResolve.sv
source/fetchFrontEnd.sv
bench/frontEndTb.sv
